// ==== hw/csr_pkg.sv ====
// ********************
// shared widths, machine and FP CSR addresses, trap encodings
// only M-mode, one external interrupt, direct mtvec mode
// fcsr is a view of frm and fflags, no storage of its own
// ********************

package csr_pkg;

    // data path widths
    localparam int unsigned XLEN        = 32;
    localparam int unsigned CSR_ADDR_W  = 12;
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned COMMIT_ID_W = 3;

    // FP status field widths
    localparam int unsigned FFLAGS_W = 5; // NV DZ OF UF NX
    localparam int unsigned FRM_W    = 3;

    // machine CSRs
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // FP CSRs, user level
    localparam logic [CSR_ADDR_W-1:0] CSR_FFLAGS = 12'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_FRM    = 12'h002;
    localparam logic [CSR_ADDR_W-1:0] CSR_FCSR   = 12'h003;

    // counters, low and high halves
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;

    // mstatus bit positions
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7; // holds MIE across a trap

    // interrupt bit set, code 11 = machine external
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INT = 32'h8000_000B;

    // interrupt entry sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0, // normal execution
        SAVE   = 2'd1, // mepc/mcause/mstatus written at end of cycle
        VECTOR = 2'd2  // one-cycle fetch redirect to mtvec
    } trap_state_t;

endpackage

// ==== hw/csr_exec_unit.sv ====
// ********************
// execute-stage CSR op is purely combinational apart from checks
// operand arrives already selected and has no immediate form
// inputs must stay stable while csr_stall_o is high
// ********************
`timescale 1ns/10ps

module csr_exec_unit (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           req_csr_i,
    input  logic                           csrrw_i,
    input  logic                           csrrs_i,
    input  logic                           csrrc_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]        csr_op1_i,
    input  logic                           rd_we_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i,
    input  logic [csr_pkg::XLEN-1:0]        csr_rdata_i,     // old CSR value
    input  logic                           int_assert_i,
    input  logic                           fflags_pending_i,
    input  logic                           wb_ready_i,
    output logic                           csr_we_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr_o,
    output logic [csr_pkg::XLEN-1:0]        csr_wdata_o,
    output logic [csr_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic                           reg_we_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_o,
    output logic                           csr_stall_o
);
    import csr_pkg::*;

    logic valid_op;     // request not killed by trap entry
    logic fp_access;    // touches accrued flags
    logic fp_conflict;  // flags still in flight from the FPU
    logic op_writes;    // op changes the CSR at all
    logic [XLEN-1:0] new_val;

    assign valid_op    = req_csr_i & ~int_assert_i;
    assign fp_access   = (csr_addr_i == CSR_FFLAGS) || (csr_addr_i == CSR_FCSR);
    assign fp_conflict = valid_op & fp_access & fflags_pending_i;

    // set/clear with zero operand is a pure read
    assign op_writes = csrrw_i | ((csrrs_i | csrrc_i) & (|csr_op1_i));

    always_comb begin
        new_val = csr_rdata_i;
        if (csrrw_i) begin
            new_val = csr_op1_i;
        end else if (csrrs_i) begin
            new_val = csr_rdata_i | csr_op1_i;  // set bits
        end else if (csrrc_i) begin
            new_val = csr_rdata_i & ~csr_op1_i; // clear bits
        end
    end

    // rd gets the old value and is held back while flags are stale
    assign reg_we_o    = valid_op & rd_we_i & ~fp_conflict;
    assign reg_wdata_o = valid_op ? csr_rdata_i : '0;
    assign reg_waddr_o = reg_waddr_i;
    assign commit_id_o = commit_id_i;

    // back-pressure from write-back or an accrual race on fflags/fcsr
    assign csr_stall_o = (reg_we_o & ~wb_ready_i) | fp_conflict;

    assign csr_we_o    = valid_op & op_writes & ~csr_stall_o;
    assign csr_waddr_o = csr_addr_i;
    assign csr_wdata_o = new_val;

    // decode upstream must never hand over two ops at once
    a_op_onehot: assert property (@(posedge clk) disable iff (reset_i)
        req_csr_i |-> $onehot({csrrw_i, csrrs_i, csrrc_i}));

    // upstream keeps a stalled op unchanged until the stall drops
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset_i)
        csr_stall_o |=> $stable({req_csr_i, csrrw_i, csrrs_i, csrrc_i, csr_addr_i,
                                 csr_op1_i, rd_we_i, reg_waddr_i, commit_id_i}));

endmodule

// ==== hw/csr_reg_file.sv ====
// ********************
// machine and FP CSR storage, async read, one write port
// trap save outranks an instruction write
// unknown addresses read zero, writes to them are dropped
// mtvec/mepc low two bits are always zero (direct mode)
// ********************
`timescale 1ns/10ps

module csr_reg_file (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,
    input  logic                          we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i,
    input  logic                          trap_save_i,
    input  logic [csr_pkg::XLEN-1:0]       trap_pc_i,
    input  logic [csr_pkg::FFLAGS_W-1:0]   fflags_acc_i,
    input  logic                          fflags_acc_valid_i,
    output logic                          mie_o,
    output logic [csr_pkg::XLEN-1:0]       mtvec_o
);
    import csr_pkg::*;

    logic                mie_q;
    logic                mpie_q;
    logic [XLEN-1:0]     mtvec_q;
    logic [XLEN-1:0]     mepc_q;
    logic [XLEN-1:0]     mcause_q;
    logic [XLEN-1:0]     mscratch_q;
    logic [FFLAGS_W-1:0] fflags_q;
    logic [FRM_W-1:0]    frm_q;

    logic [XLEN-1:0]     mstatus_rd;   // composed mstatus view
    logic [FFLAGS_W-1:0] acc_mask;     // accrued flags this cycle
    logic                wr_fflags;
    logic                wr_fcsr;

    always_comb begin
        mstatus_rd                   = '0;
        mstatus_rd[MSTATUS_MIE_BIT]  = mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT] = mpie_q;
    end

    always_comb begin
        case (raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus_rd;
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause_q;
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_FFLAGS:   rdata_o = {{(XLEN-FFLAGS_W){1'b0}}, fflags_q};
            CSR_FRM:      rdata_o = {{(XLEN-FRM_W){1'b0}}, frm_q};
            CSR_FCSR:     rdata_o = {{(XLEN-FRM_W-FFLAGS_W){1'b0}}, frm_q, fflags_q};
            default:      rdata_o = '0; // not implemented here
        endcase
    end

    assign acc_mask  = fflags_acc_valid_i ? fflags_acc_i : '0;
    assign wr_fflags = we_i && (waddr_i == CSR_FFLAGS);
    assign wr_fcsr   = we_i && (waddr_i == CSR_FCSR);

    // trap-visible state: mstatus, mepc, mcause
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (trap_save_i) begin
            mpie_q   <= mie_q;           // stash old enable
            mie_q    <= 1'b0;            // interrupts off in handler
            mepc_q   <= {trap_pc_i[XLEN-1:2], 2'b00};
            mcause_q <= CAUSE_M_EXT_INT;
        end else if (we_i) begin
            case (waddr_i)
                CSR_MSTATUS: begin
                    mie_q  <= wdata_i[MSTATUS_MIE_BIT];
                    mpie_q <= wdata_i[MSTATUS_MPIE_BIT];
                end
                CSR_MEPC:   mepc_q   <= {wdata_i[XLEN-1:2], 2'b00};
                CSR_MCAUSE: mcause_q <= wdata_i;
                default: ;
            endcase
        end
    end

    // plain machine registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else if (we_i) begin
            if (waddr_i == CSR_MTVEC) mtvec_q <= {wdata_i[XLEN-1:2], 2'b00};
            if (waddr_i == CSR_MSCRATCH) mscratch_q <= wdata_i;
        end
    end

    // FP status; instruction write lands first, accrual ORs on top
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fflags_q <= '0;
            frm_q    <= '0;
        end else begin
            if (wr_fflags || wr_fcsr) begin
                fflags_q <= wdata_i[FFLAGS_W-1:0] | acc_mask;
            end else begin
                fflags_q <= fflags_q | acc_mask;
            end
            if (wr_fcsr) begin
                frm_q <= wdata_i[FFLAGS_W+FRM_W-1:FFLAGS_W]; // rm sits above flags
            end else if (we_i && (waddr_i == CSR_FRM)) begin
                frm_q <= wdata_i[FRM_W-1:0];
            end
        end
    end

    assign mie_o   = mie_q;
    assign mtvec_o = mtvec_q;

    // exec unit is suppressed during SAVE, so the ports never collide
    a_save_no_collide: assert property (@(posedge clk) disable iff (reset_i)
        trap_save_i |-> !(we_i && (waddr_i == CSR_MEPC || waddr_i == CSR_MCAUSE)));

endmodule

// ==== hw/csr_counter.sv ====
// ********************
// 64-bit mcycle and minstret, written in 32-bit halves
// a half write replaces the increment in that cycle
// ********************
`timescale 1ns/10ps

module csr_counter (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          retire_i,  // one instruction retired
    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,
    output logic                          hit_o,     // raddr is a counter
    input  logic                          we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i
);
    import csr_pkg::*;

    logic [2*XLEN-1:0] mcycle_q;
    logic [2*XLEN-1:0] minstret_q;

    always_comb begin
        hit_o   = 1'b1;
        rdata_o = '0;
        case (raddr_i)
            CSR_MCYCLE:    rdata_o = mcycle_q[XLEN-1:0];
            CSR_MCYCLEH:   rdata_o = mcycle_q[2*XLEN-1:XLEN];
            CSR_MINSTRET:  rdata_o = minstret_q[XLEN-1:0];
            CSR_MINSTRETH: rdata_o = minstret_q[2*XLEN-1:XLEN];
            default:       hit_o   = 1'b0; // reg file answers
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mcycle_q <= '0;
        end else if (we_i && waddr_i == CSR_MCYCLE) begin
            mcycle_q[XLEN-1:0] <= wdata_i;
        end else if (we_i && waddr_i == CSR_MCYCLEH) begin
            mcycle_q[2*XLEN-1:XLEN] <= wdata_i;
        end else begin
            mcycle_q <= mcycle_q + 1'b1; // free running
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            minstret_q <= '0;
        end else if (we_i && waddr_i == CSR_MINSTRET) begin
            minstret_q[XLEN-1:0] <= wdata_i;
        end else if (we_i && waddr_i == CSR_MINSTRETH) begin
            minstret_q[2*XLEN-1:XLEN] <= wdata_i;
        end else if (retire_i) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

endmodule

// ==== hw/csr_trap_fsm.sv ====
// ********************
// interrupt entry sequencer IDLE -> SAVE -> VECTOR -> IDLE
// int_req_i sampled only in IDLE with MIE set and no stall
// redirect pulse comes 2 cycles after the sampling edge
// ********************
`timescale 1ns/10ps

module csr_trap_fsm (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    int_req_i,     // level from the interrupt source
    input  logic                    mie_i,
    input  logic                    stall_i,       // exec unit mid-operation
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    output logic                    int_assert_o,  // kills the current CSR op
    output logic                    trap_save_o,   // save strobe to the reg file
    output logic                    redirect_o,
    output logic [csr_pkg::XLEN-1:0] redirect_pc_o
);
    import csr_pkg::*;

    trap_state_t state_q;
    trap_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // wait for a clean boundary before taking the interrupt
                if (int_req_i && mie_i && !stall_i) begin
                    state_d = SAVE;
                end
            end
            SAVE:    state_d = VECTOR; // save lands at end of SAVE
            VECTOR:  state_d = IDLE;
            default: state_d = IDLE;   // unused encoding
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign int_assert_o  = (state_q == SAVE);
    assign trap_save_o   = (state_q == SAVE);
    assign redirect_o    = (state_q == VECTOR);
    assign redirect_pc_o = mtvec_i; // direct mode only

    // an accepted request gives one save cycle and then a single redirect pulse
    a_entry_sequence: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == IDLE && int_req_i && mie_i && !stall_i)
        |=> trap_save_o ##1 (redirect_o && !trap_save_o) ##1 !redirect_o);

    // a redirect always traces back to a request taken two edges earlier
    a_redirect_source: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |-> $past(int_req_i && mie_i && !stall_i, 2));

endmodule

// ==== hw/csr_subsys_top.sv ====
// ********************
// CSR subsystem, exec unit + CSR file + counters + trap FSM
// op is combinational from req_csr_i to the rd result
// CSR writes land at the edge ending an unstalled cycle
// ********************
`timescale 1ns/10ps

module csr_subsys_top (
    input  logic                           clk,
    input  logic                           reset_i,
    // instruction side
    input  logic                           req_csr_i,
    input  logic                           csrrw_i,
    input  logic                           csrrs_i,
    input  logic                           csrrc_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]        csr_op1_i,
    input  logic                           rd_we_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i,
    input  logic [csr_pkg::XLEN-1:0]        pc_i,
    // write-back and FPU
    input  logic                           wb_ready_i,
    input  logic                           fflags_pending_i,
    input  logic [csr_pkg::FFLAGS_W-1:0]    fflags_acc_i,
    input  logic                           fflags_acc_valid_i,
    // interrupt and retire
    input  logic                           int_req_i,
    input  logic                           retire_i,
    // results
    output logic [csr_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic                           reg_we_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_o,
    output logic                           csr_stall_o,
    output logic                           redirect_o,
    output logic [csr_pkg::XLEN-1:0]        redirect_pc_o
);
    import csr_pkg::*;

    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;
    logic [XLEN-1:0]       rf_rdata;
    logic [XLEN-1:0]       cnt_rdata;
    logic                  cnt_hit;
    logic [XLEN-1:0]       csr_rdata;   // old value into the exec unit
    logic                  int_assert;
    logic                  trap_save;
    logic                  mie;
    logic [XLEN-1:0]       mtvec;

    assign csr_rdata = cnt_hit ? cnt_rdata : rf_rdata; // counters decode their own range

    csr_exec_unit u_exec (
        .clk(clk), .reset_i(reset_i),
        .req_csr_i(req_csr_i), .csrrw_i(csrrw_i), .csrrs_i(csrrs_i), .csrrc_i(csrrc_i),
        .csr_addr_i(csr_addr_i), .csr_op1_i(csr_op1_i), .rd_we_i(rd_we_i),
        .reg_waddr_i(reg_waddr_i), .commit_id_i(commit_id_i), .csr_rdata_i(csr_rdata),
        .int_assert_i(int_assert), .fflags_pending_i(fflags_pending_i),
        .wb_ready_i(wb_ready_i),
        .csr_we_o(csr_we), .csr_waddr_o(csr_waddr), .csr_wdata_o(csr_wdata),
        .reg_wdata_o(reg_wdata_o), .reg_waddr_o(reg_waddr_o), .reg_we_o(reg_we_o),
        .commit_id_o(commit_id_o), .csr_stall_o(csr_stall_o)
    );

    csr_reg_file u_regs (
        .clk(clk), .reset_i(reset_i),
        .raddr_i(csr_addr_i), .rdata_o(rf_rdata),
        .we_i(csr_we), .waddr_i(csr_waddr), .wdata_i(csr_wdata),
        .trap_save_i(trap_save), .trap_pc_i(pc_i),
        .fflags_acc_i(fflags_acc_i), .fflags_acc_valid_i(fflags_acc_valid_i),
        .mie_o(mie), .mtvec_o(mtvec)
    );

    csr_counter u_cnt (
        .clk(clk), .reset_i(reset_i), .retire_i(retire_i),
        .raddr_i(csr_addr_i), .rdata_o(cnt_rdata), .hit_o(cnt_hit),
        .we_i(csr_we), .waddr_i(csr_waddr), .wdata_i(csr_wdata)
    );

    csr_trap_fsm u_trap (
        .clk(clk), .reset_i(reset_i),
        .int_req_i(int_req_i), .mie_i(mie), .stall_i(csr_stall_o), .mtvec_i(mtvec),
        .int_assert_o(int_assert), .trap_save_o(trap_save),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
    );

endmodule

// ==== verification/csr_subsys_tb.sv ====
// ********************
// stimulus and expected values come from verification/csr_patterns.txt
// run from the project root so that the relative path resolves
// reference model covers every CSR and counts mcycle from reset release
// ops, interrupts and flag accrual never overlap
// ********************
`timescale 1ns/10ps

module csr_subsys_tb;
    import csr_pkg::*;

    localparam int TIMEOUT = 40; // cycles allowed per wait loop

    logic clk = 1'b0;
    logic reset_i, req_csr_i, csrrw_i, csrrs_i, csrrc_i, rd_we_i;
    logic [CSR_ADDR_W-1:0]  csr_addr_i;
    logic [XLEN-1:0]        csr_op1_i, pc_i;
    logic [REG_ADDR_W-1:0]  reg_waddr_i, reg_waddr_o;
    logic [COMMIT_ID_W-1:0] commit_id_i, commit_id_o;
    logic wb_ready_i, fflags_pending_i, fflags_acc_valid_i, int_req_i, retire_i;
    logic [FFLAGS_W-1:0]    fflags_acc_i;
    logic [XLEN-1:0]        reg_wdata_o, redirect_pc_o;
    logic reg_we_o, csr_stall_o, redirect_o;

    // reference model of the architectural state
    logic [XLEN-1:0] m_mtvec, m_mepc, m_mcause, m_mscratch;
    logic            m_mie, m_mpie;
    logic [4:0]      m_fflags;
    logic [2:0]      m_frm;
    logic [63:0]     m_minstret;
    logic [63:0]     m_mcycle;
    logic [15:0]     lfsr = 16'd57887;
    int              pend_next;   // pending-flags cycles for the next op

    always #5 clk = ~clk;

    // mcycle advances on every edge once reset is released
    always @(posedge clk) begin
        if (reset_i) begin
            m_mcycle <= '0;
        end else begin
            m_mcycle <= m_mcycle + 64'd1;
        end
    end

    csr_subsys_top dut0 (.*);

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        assert (got === exp)
        else fail_now($sformatf("Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    // galois LFSR over x^16+x^14+x^13+x^11+1
    function automatic int draw_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // one step per bit taken
        end
        return val;
    endfunction

    function automatic logic [XLEN-1:0] read_model(input logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_MSTATUS:   return {24'b0, m_mpie, 3'b0, m_mie, 3'b0}; // MPIE at 7 and MIE at 3
            CSR_MTVEC:     return m_mtvec;
            CSR_MEPC:      return m_mepc;
            CSR_MCAUSE:    return m_mcause;
            CSR_MSCRATCH:  return m_mscratch;
            CSR_FFLAGS:    return {27'b0, m_fflags};
            CSR_FRM:       return {29'b0, m_frm};
            CSR_FCSR:      return {24'b0, m_frm, m_fflags};
            CSR_MINSTRET:  return m_minstret[31:0];
            CSR_MINSTRETH: return m_minstret[63:32];
            default:       return '0;
        endcase
    endfunction

    task automatic write_model(input logic [CSR_ADDR_W-1:0] a, input logic [XLEN-1:0] v);
        case (a)
            CSR_MSTATUS: begin
                m_mie  = v[3];
                m_mpie = v[7];
            end
            CSR_MTVEC:     m_mtvec = {v[31:2], 2'b00}; // word aligned in direct mode
            CSR_MEPC:      m_mepc = {v[31:2], 2'b00};
            CSR_MCAUSE:    m_mcause = v;
            CSR_MSCRATCH:  m_mscratch = v;
            CSR_FFLAGS:    m_fflags = v[4:0];
            CSR_FRM:       m_frm = v[2:0];
            CSR_FCSR: begin
                m_frm    = v[7:5];
                m_fflags = v[4:0];
            end
            CSR_MINSTRET:  m_minstret[31:0] = v;
            CSR_MINSTRETH: m_minstret[63:32] = v;
            default: ;
        endcase
    endtask

    task automatic run_csr_op(input logic [63:0] kind, input logic [CSR_ADDR_W-1:0] a,
                              input logic [XLEN-1:0] opnd, input logic [XLEN-1:0] expv,
                              input int stall_bits, input int idx);
        logic [XLEN-1:0] old_v;
        int bp_len;
        int hold;
        int waited;
        bit is_cycle;
        is_cycle = (a == CSR_MCYCLE);
        old_v = read_model(a);
        bp_len = 0;
        if (stall_bits > 0) begin
            bp_len = draw_bits(stall_bits) + 1; // at least one cycle of back-pressure
        end
        hold = (bp_len > pend_next) ? bp_len : pend_next;
        if (!is_cycle) begin
            assert (old_v === expv) else fail_now("pattern file and model disagree on old value");
        end
        @(posedge clk);
        req_csr_i        <= 1'b1;
        csrrw_i          <= (kind == "rw");
        csrrs_i          <= (kind == "rs");
        csrrc_i          <= (kind == "rc");
        csr_addr_i       <= a;
        csr_op1_i        <= opnd;
        rd_we_i          <= 1'b1;
        reg_waddr_i      <= idx[4:0];
        commit_id_i      <= idx[2:0];
        wb_ready_i       <= (bp_len == 0);
        fflags_pending_i <= (pend_next > 0);
        for (int c = 0; c < hold; c++) begin
            @(negedge clk);
            check_val("csr_stall_o", 32'(csr_stall_o), 32'd1);
            check_val("reg_wdata_o", reg_wdata_o, old_v);     // CSR untouched while held
            check_val("reg_we_o", 32'(reg_we_o), 32'(c >= pend_next)); // no rd with stale flags
            @(posedge clk);
            if (c + 1 >= bp_len) wb_ready_i <= 1'b1;
            if (c + 1 >= pend_next) fflags_pending_i <= 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (csr_stall_o !== 1'b0) begin
            assert (waited < TIMEOUT) else fail_now("timeout waiting for csr_stall_o to drop");
            @(negedge clk);
            waited++;
        end
        if (is_cycle) begin
            check_val("reg_wdata_o", reg_wdata_o, m_mcycle[31:0]); // strictly rising by model
        end else begin
            check_val("reg_wdata_o", reg_wdata_o, expv);
        end
        check_val("reg_we_o", 32'(reg_we_o), 32'd1);
        check_val("reg_waddr_o", 32'(reg_waddr_o), 32'(idx[4:0])); // echoes
        check_val("commit_id_o", 32'(commit_id_o), 32'(idx[2:0]));
        @(posedge clk);                                            // write lands here
        req_csr_i <= 1'b0;
        csrrw_i   <= 1'b0;
        csrrs_i   <= 1'b0;
        csrrc_i   <= 1'b0;
        rd_we_i   <= 1'b0;
        if (kind == "rw") write_model(a, opnd);
        else if (kind == "rs" && opnd != 0) write_model(a, old_v | opnd);
        else if (kind == "rc" && opnd != 0) write_model(a, old_v & ~opnd);
        pend_next = 0;
    endtask

    task automatic raise_interrupt(input logic [XLEN-1:0] pc, input logic expect_redir);
        int cnt;
        assert (m_mie === expect_redir) else fail_now("pattern file and model disagree on MIE");
        @(posedge clk);
        int_req_i <= 1'b1;
        pc_i      <= pc;
        cnt = 0;
        if (expect_redir) begin
            do begin
                @(posedge clk);
                cnt++; // first edge here samples the request
                @(negedge clk);
                assert (cnt <= TIMEOUT) else fail_now("timeout waiting for redirect_o");
            end while (redirect_o !== 1'b1);
            assert (cnt == 2)
            else fail_now($sformatf("redirect came %0d cycles after sampling, not 2", cnt));
            check_val("redirect_pc_o", redirect_pc_o, m_mtvec);
            @(posedge clk);
            int_req_i <= 1'b0;
            @(negedge clk);
            check_val("redirect_o", 32'(redirect_o), 32'd0); // single pulse
            m_mepc   = {pc[31:2], 2'b00};
            m_mcause = CAUSE_M_EXT_INT;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end else begin
            repeat (TIMEOUT) begin
                @(negedge clk);
                check_val("redirect_o", 32'(redirect_o), 32'd0); // masked by MIE
            end
            @(posedge clk);
            int_req_i <= 1'b0;
        end
    endtask

    initial begin
        int fd;
        int n;
        int idx;
        int bits;
        string line;
        logic [63:0] cmd;
        logic [63:0] kind;
        logic [CSR_ADDR_W-1:0] a;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] expv;
        reset_i <= 1'b1;
        {req_csr_i, csrrw_i, csrrs_i, csrrc_i, rd_we_i} <= '0;
        {csr_addr_i, csr_op1_i, pc_i, reg_waddr_i, commit_id_i} <= '0;
        {wb_ready_i, fflags_pending_i, fflags_acc_valid_i, int_req_i, retire_i} <= '0;
        fflags_acc_i <= '0;
        {m_mtvec, m_mepc, m_mcause, m_mscratch} = '0;
        {m_mie, m_mpie, m_fflags, m_frm, m_minstret} = '0;
        pend_next = 0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_val("redirect_o", 32'(redirect_o), 32'd0);
        check_val("reg_we_o", 32'(reg_we_o), 32'd0);
        check_val("csr_stall_o", 32'(csr_stall_o), 32'd0);
        fd = $fopen("verification/csr_patterns.txt", "r");
        assert (fd != 0) else fail_now("could not open verification/csr_patterns.txt");
        idx = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") continue; // blank or comment
            n = $sscanf(line, "%s %s %h %h %h %d", cmd, kind, a, data, expv, bits);
            assert (n == 6) else fail_now($sformatf("malformed pattern line: %s", line));
            idx++;
            if (cmd == "op") begin
                run_csr_op(kind, a, data, expv, bits, idx);
            end else if (cmd == "int") begin
                raise_interrupt(data, expv[0]);
            end else if (cmd == "flags") begin
                @(posedge clk);
                fflags_acc_i       <= data[4:0];
                fflags_acc_valid_i <= 1'b1;
                @(posedge clk);
                fflags_acc_valid_i <= 1'b0;
                m_fflags  = m_fflags | data[4:0]; // accrual ORs in
                pend_next = bits;
            end else if (cmd == "retire") begin
                repeat (data) begin
                    @(posedge clk);
                    retire_i <= 1'b1;
                end
                @(posedge clk);
                retire_i <= 1'b0;
                m_minstret = m_minstret + 64'(data);
            end else begin
                fail_now($sformatf("unknown command in pattern line: %s", line));
            end
        end
        $fclose(fd);
        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verification/csr_patterns.txt ====
# cmd kind addr data expect stall; op: kind rw/rs/rc, expect = old CSR value on rd
# op stall = LFSR bits drawn for wb_ready back-pressure; flags stall = pending cycles of next op
# int: data = pc, expect 1 = redirect; retire: data = pulses; mcycle reads ignore expect
op rw 340 a5a5f00f 00000000 0
op rs 340 00000ff0 a5a5f00f 3
op rc 340 0000000f a5a5ffff 2
op rs 340 00000000 a5a5fff0 0
op rc 340 00000000 a5a5fff0 0
op rs 340 00000000 a5a5fff0 0
op rw 305 80001003 00000000 2
op rc 305 00001000 80001000 0
op rs 305 00000104 80000000 1
op rs 305 00000000 80000104 0
int - 0 00000200 00000000 0
op rs 300 00000008 00000000 0
int - 0 00000246 00000001 0
op rs 341 00000000 00000244 0
op rs 342 00000000 8000000b 0
op rs 300 00000000 00000080 0
flags - 0 00000005 00000000 0
op rw 002 00000006 00000000 0
flags - 0 00000012 00000000 2
op rs 003 00000000 000000d7 0
op rc 001 00000001 00000017 0
op rs 003 00000000 000000d6 0
retire - 0 00000007 00000000 0
op rs b02 00000000 00000007 0
op rw b02 00000100 00000007 0
op rs b02 00000000 00000100 0
op rs b00 00000000 00000000 0
op rs b00 00000000 00000000 0

// ==== build.f ====
hw/csr_pkg.sv
hw/csr_exec_unit.sv
hw/csr_reg_file.sv
hw/csr_counter.sv
hw/csr_trap_fsm.sv
hw/csr_subsys_top.sv
verification/csr_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile and run the CSR subsystem testbench, verdict from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module csr_subsys_tb -f build.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vcsr_subsys_tb > sim.log 2>&1 || true
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log || exit 1
